// File: hw/iq_commit.sv
// ==========================================================================
// in-order commit
// retires up to two valid done entries per cycle from the heads and
// registers their tags and targets on the commit outputs
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module iq_commit import iq_pkg::*; #(
	parameter int QENTRIES = 8
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic [QENTRIES-1:0]         iq_v,
	input  wire iq_entry_t [QENTRIES-1:0]    iq,
	output logic [$clog2(QENTRIES)-1:0]      heads0,
	output logic [$clog2(QENTRIES)-1:0]      heads1,
	output logic                             ret0,
	output logic                             ret1,
	output logic                             cmt0_v,
	output tag_t                             cmt0_tag,
	output reg_t                             cmt0_tgt,
	output logic                             cmt1_v,
	output tag_t                             cmt1_tag,
	output reg_t                             cmt1_tgt
);

	localparam int IW = $clog2(QENTRIES);

	logic [IW-1:0] adv;

	// second head always sits right behind the first
	assign heads1 = heads0 + IW'(1);

	// ======================================================================
	// retire decision
	// ======================================================================

	// head 0 goes when valid and done
	assign ret0 = (iq_v[heads0] == VAL) && iq[heads0].done;

	// head 1 only alongside head 0, never past a waiting entry
	assign ret1 = ret0 && (iq_v[heads1] == VAL) && iq[heads1].done;

	// zero, one or two
	assign adv = {{(IW-1){1'b0}}, ret0} + {{(IW-1){1'b0}}, ret1};

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			heads0 <= '0;
			cmt0_v <= 1'b0;
			cmt1_v <= 1'b0;
		end else begin
			heads0 <= heads0 + adv;
			cmt0_v <= ret0;
			cmt1_v <= ret1;
		end
	end

	// ======================================================================
	// commit payload
	// ======================================================================

	// only meaningful while the matching strobe is high
	always_ff @(posedge clk) begin
		cmt0_tag <= iq[heads0].tag;
		cmt0_tgt <= iq[heads0].tgt;
		cmt1_tag <= iq[heads1].tag;
		cmt1_tgt <= iq[heads1].tgt;
	end

endmodule

`default_nettype wire

// File: hw/iq_enq_if.sv
// ==========================================================================
// enqueue bus
// carries the registered instruction pair and its strobes from fetch
// capture to tail allocation and valid tracking
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

interface iq_enq_if import iq_pkg::*; #(
	parameter int QENTRIES = 8
) ();

	// en1 only ever high together with en0
	logic      en0;
	logic      en1;
	iq_entry_t ins0;
	iq_entry_t ins1;
	logic      backbr0;

	// number of entries entering the queue this cycle, sized to the depth
	function automatic logic [$clog2(QENTRIES):0] enq_count();
		enq_count = {{$clog2(QENTRIES){1'b0}}, en0} + {{$clog2(QENTRIES){1'b0}}, en1};
	endfunction

	modport fetch (output en0, en1, ins0, ins1, backbr0);
	modport alloc (input en0, en1, ins0, ins1, backbr0, import enq_count);
	modport valid (input en0, en1);

endinterface

`default_nettype wire

// File: hw/iq_fetch_capture.sv
// ==========================================================================
// fetch capture
// registers the two-slot fetch pair and decides which slots enqueue,
// using the predicate for a lone slot 0 and the backward-branch rule
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module iq_fetch_capture import iq_pkg::*; #(
	parameter int QENTRIES = 8
) (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      in0_v,
	input  wire logic      in1_v,
	input  wire iq_entry_t in0_ins,
	input  wire iq_entry_t in1_ins,
	input  wire logic [1:0] pred_mask,
	input  wire logic [1:0] pred_val,
	iq_enq_if.fetch        enq
);

	// the queue must take the pair held here plus the pair at the inputs
	if (QENTRIES < 4) begin : g_depth_check
		$error("instruction queue needs at least 4 entries");
	end

	logic      pred_ok;
	logic      nxt_en0;
	logic      nxt_en1;
	iq_entry_t slot0;

	// even parity on the mask, or an exact match, lets the instruction through
	assign pred_ok = (~^pred_mask) || (pred_mask == pred_val);

	always_comb begin
		nxt_en0 = 1'b0;
		nxt_en1 = 1'b0;
		slot0 = in0_ins;
		case ({in0_v, in1_v})
			2'b01: begin
				// lone slot 1 moves down into slot 0
				nxt_en0 = 1'b1;
				slot0 = in1_ins;
			end
			2'b10: nxt_en0 = pred_ok;
			2'b11: begin
				// backward branch in slot 0 keeps slot 1 out
				nxt_en0 = 1'b1;
				nxt_en1 = !in0_ins.backbr;
			end
			default: ;
		endcase
	end

	// strobes
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			enq.en0 <= 1'b0;
			enq.en1 <= 1'b0;
		end else begin
			enq.en0 <= nxt_en0;
			enq.en1 <= nxt_en1;
		end
	end

	// payload, done always starts clear
	always_ff @(posedge clk) begin
		enq.ins0 <= '{done: 1'b0, backbr: slot0.backbr, tgt: slot0.tgt, tag: slot0.tag};
		enq.ins1 <= '{done: 1'b0, backbr: in1_ins.backbr, tgt: in1_ins.tgt, tag: in1_ins.tag};
		enq.backbr0 <= slot0.backbr;
	end

endmodule

`default_nettype wire

// File: hw/iq_pkg.sv
// ==========================================================================
// instruction queue package
// shared entry layout, tag and register types and the valid-bit encoding
// used by every stage of the queue bookkeeping
// ==========================================================================
`default_nettype none

package iq_pkg;

	// valid bit values for an occupied and a free entry
	localparam logic VAL = 1'b1;
	localparam logic INV = 1'b0;

	// sequence tag carried through to commit
	typedef logic [7:0] tag_t;

	// target register, zero means no write
	typedef logic [4:0] reg_t;

	// one queue entry, 15 bits
	typedef struct packed {
		logic done;
		logic backbr;
		reg_t tgt;
		tag_t tag;
	} iq_entry_t;

endpackage

`default_nettype wire

// File: hw/iq_tail_alloc.sv
// ==========================================================================
// tail allocation
// owns the tail pointer and the entry payloads, applies done marks,
// rolls the tail back on a branch miss and reports queue_full
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module iq_tail_alloc import iq_pkg::*; #(
	parameter int QENTRIES = 8
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	iq_enq_if.alloc                          enq,
	input  wire logic                        miss_v,
	input  wire logic [$clog2(QENTRIES)-1:0] miss_idx,
	input  wire logic                        done_v,
	input  wire logic [$clog2(QENTRIES)-1:0] done_idx,
	input  wire logic [QENTRIES-1:0]         iq_v,
	input  wire logic [$clog2(QENTRIES)-1:0] heads0,
	output logic [$clog2(QENTRIES)-1:0]      tail0,
	output logic [$clog2(QENTRIES)-1:0]      tail1,
	output logic [QENTRIES-1:0]              stomp,
	output logic                             branchmiss,
	output iq_entry_t [QENTRIES-1:0]         iq,
	output logic                             queue_full
);

	localparam int IW = $clog2(QENTRIES);

	logic [IW-1:0] span;
	logic [IW-1:0] gap;
	logic [IW:0]   free_cnt;

	// ======================================================================
	// branch miss
	// ======================================================================

	assign branchmiss = miss_v;

	// entries strictly after miss_idx and before tail0
	assign span = tail0 - miss_idx - IW'(1);

	always_comb begin
		for (int i = 0; i < QENTRIES; i++) begin
			// offset of entry i past the missed branch, wrapping around
			stomp[i] = miss_v && (iq_v[i] == VAL) && ((IW'(i) - miss_idx - IW'(1)) < span);
		end
	end

	// ======================================================================
	// tail pointer
	// ======================================================================

	assign tail1 = tail0 + IW'(1);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			tail0 <= '0;
		end else if (miss_v) begin
			// captured pair is dropped, tail restarts behind the branch
			tail0 <= miss_idx + IW'(1);
		end else begin
			tail0 <= tail0 + IW'(enq.enq_count());
		end
	end

	// entry payloads
	always_ff @(posedge clk) begin
		if (done_v)
			iq[done_idx].done <= 1'b1;
		// nothing is written during a miss
		if (!miss_v && enq.en0) begin
			// slot 0 branch flag travels on its own wire
			iq[tail0] <= '{done: 1'b0, backbr: enq.backbr0, tgt: enq.ins0.tgt,
				tag: enq.ins0.tag};
		end
		if (!miss_v && enq.en1)
			iq[tail1] <= enq.ins1;
	end

	// ======================================================================
	// free count
	// ======================================================================

	// occupied entries run from heads0 up to tail0 without holes
	assign gap = heads0 - tail0;

	always_comb begin
		if (tail0 == heads0)
			// equal pointers, empty or completely full
			free_cnt = (iq_v[heads0] == VAL) ? '0 : (IW+1)'(QENTRIES);
		else
			free_cnt = {1'b0, gap};
	end

	// two for the pair in capture, two for the pair at the inputs
	assign queue_full = free_cnt < (IW+1)'(4);

endmodule

`default_nettype wire

// File: hw/iq_top.sv
// ==========================================================================
// instruction queue top level
// fetch capture, tail allocation, valid tracking and commit in order
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module iq_top import iq_pkg::*; #(
	parameter int QENTRIES = 8
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        in0_v,
	input  wire logic                        in1_v,
	input  wire tag_t                        in0_tag,
	input  wire reg_t                        in0_tgt,
	input  wire logic                        in0_backbr,
	input  wire tag_t                        in1_tag,
	input  wire reg_t                        in1_tgt,
	input  wire logic                        in1_backbr,
	input  wire logic [1:0]                  pred_mask,
	input  wire logic [1:0]                  pred_val,
	input  wire logic                        done_v,
	input  wire logic [$clog2(QENTRIES)-1:0] done_idx,
	input  wire logic                        miss_v,
	input  wire logic [$clog2(QENTRIES)-1:0] miss_idx,
	output logic                             queue_full,
	output logic                             cmt0_v,
	output tag_t                             cmt0_tag,
	output reg_t                             cmt0_tgt,
	output logic                             cmt1_v,
	output tag_t                             cmt1_tag,
	output reg_t                             cmt1_tgt
);

	localparam int IW = $clog2(QENTRIES);

	iq_entry_t               in0_ins;
	iq_entry_t               in1_ins;
	logic [IW-1:0]           tail0;
	logic [IW-1:0]           tail1;
	logic [IW-1:0]           heads0;
	logic [IW-1:0]           heads1;
	logic [QENTRIES-1:0]     stomp;
	logic [QENTRIES-1:0]     iq_v;
	logic                    branchmiss;
	logic                    ret0;
	logic                    ret1;
	iq_entry_t [QENTRIES-1:0] iq;

	// fetch slots become queue entries, not yet done
	assign in0_ins = '{done: 1'b0, backbr: in0_backbr, tgt: in0_tgt, tag: in0_tag};
	assign in1_ins = '{done: 1'b0, backbr: in1_backbr, tgt: in1_tgt, tag: in1_tag};

	iq_enq_if #(.QENTRIES(QENTRIES)) enq ();

	iq_fetch_capture #(.QENTRIES(QENTRIES)) u_fetch (
		.clk, .rst, .in0_v, .in1_v, .in0_ins, .in1_ins, .pred_mask, .pred_val,
		.enq(enq)
	);

	iq_tail_alloc #(.QENTRIES(QENTRIES)) u_alloc (
		.clk, .rst, .enq(enq), .miss_v, .miss_idx, .done_v, .done_idx, .iq_v,
		.heads0, .tail0, .tail1, .stomp, .branchmiss, .iq, .queue_full
	);

	iq_valid #(.QENTRIES(QENTRIES)) u_valid (
		.clk, .rst, .enq(enq), .tail0, .tail1, .stomp, .branchmiss, .ret0, .ret1,
		.heads0, .heads1, .iq_v
	);

	iq_commit #(.QENTRIES(QENTRIES)) u_commit (
		.clk, .rst, .iq_v, .iq, .heads0, .heads1, .ret0, .ret1,
		.cmt0_v, .cmt0_tag, .cmt0_tgt, .cmt1_v, .cmt1_tag, .cmt1_tgt
	);

endmodule

`default_nettype wire

// File: hw/iq_valid.sv
// ==========================================================================
// queue valid bits
// one valid bit per entry, set on enqueue at the tail and cleared by a
// branch-miss stomp or by commit at the heads
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module iq_valid import iq_pkg::*; #(
	parameter int QENTRIES = 8
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	iq_enq_if.valid                          enq,
	input  wire logic [$clog2(QENTRIES)-1:0] tail0,
	input  wire logic [$clog2(QENTRIES)-1:0] tail1,
	input  wire logic [QENTRIES-1:0]         stomp,
	input  wire logic                        branchmiss,
	input  wire logic                        ret0,
	input  wire logic                        ret1,
	input  wire logic [$clog2(QENTRIES)-1:0] heads0,
	input  wire logic [$clog2(QENTRIES)-1:0] heads1,
	output logic [QENTRIES-1:0]              iq_v
);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			iq_v <= {QENTRIES{INV}};
		end else begin
			// enqueue, nothing goes in while a miss is being handled
			if (!branchmiss) begin
				if (enq.en0)
					iq_v[tail0] <= VAL;
				// en1 already excludes a backward branch in slot 0
				if (enq.en1)
					iq_v[tail1] <= VAL;
			end

			// clears come last so they win over a set to the same entry

			// wrong-path entries behind the missed branch
			for (int i = 0; i < QENTRIES; i++) begin
				if (stomp[i])
					iq_v[i] <= INV;
			end

			// retired entries at the heads
			if (ret0)
				iq_v[heads0] <= INV;
			if (ret1)
				iq_v[heads1] <= INV;
		end
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+testbench
hw/iq_pkg.sv
hw/iq_enq_if.sv
hw/iq_fetch_capture.sv
hw/iq_tail_alloc.sv
hw/iq_valid.sv
hw/iq_commit.sv
hw/iq_top.sv
testbench/tb_iq_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the instruction queue testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_iq_top
OBJ=obj_dir

if ! verilator --binary -j 0 --timescale 1ns/1ps --top-module "$TOP" \
	--Mdir "$OBJ" -f project.f; then
	echo "build failed"
	exit 1
fi

output=$("./$OBJ/V$TOP" 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the run passes only if the testbench printed its pass line
if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: testbench/tb_iq_model.svh
// ==========================================================================
// reference model of the instruction queue
// mirrors entries, head, tail and the captured pair, one step per edge
// ==========================================================================
`ifndef TB_IQ_MODEL_SVH
`define TB_IQ_MODEL_SVH

// queue state after the latest rising edge
logic m_v    [QENTRIES];
logic m_done [QENTRIES];
tag_t m_tag  [QENTRIES];
reg_t m_tgt  [QENTRIES];
int   m_head;
int   m_tail;

// pair held in capture, already filtered and realigned
logic cap_en0;
logic cap_en1;
tag_t cap_tag [2];
reg_t cap_tgt [2];

// commit outputs due after the next edge
logic exp_v   [2];
tag_t exp_tag [2];
reg_t exp_tgt [2];

// even parity passes, odd parity only on an exact match
function automatic logic pred_passes(input logic [1:0] mask, input logic [1:0] val);
	return (mask[0] == mask[1]) || (mask == val);
endfunction

function automatic int free_entries();
	int cnt;
	cnt = 0;
	for (int i = 0; i < QENTRIES; i++) begin
		if (!m_v[i])
			cnt++;
	end
	return cnt;
endfunction

// anything left in the queue or waiting in capture
function automatic logic queue_busy();
	return (free_entries() != QENTRIES) || cap_en0;
endfunction

task automatic clear_model();
	for (int i = 0; i < QENTRIES; i++) begin
		m_v[i] = 1'b0;
		m_done[i] = 1'b0;
		m_tag[i] = '0;
		m_tgt[i] = '0;
	end
	m_head = 0;
	m_tail = 0;
	cap_en0 = 1'b0;
	cap_en1 = 1'b0;
	exp_v[0] = 1'b0;
	exp_v[1] = 1'b0;
endtask

// one rising edge, every decision taken from the state before it
task automatic advance_model();
	int   h1;
	int   j;
	logic r0;
	logic r1;
	h1 = (m_head + 1) % QENTRIES;
	// in-order retire, second head only together with the first
	r0 = m_v[m_head] && m_done[m_head];
	r1 = r0 && m_v[h1] && m_done[h1];
	exp_v[0] = r0;
	exp_v[1] = r1;
	exp_tag[0] = m_tag[m_head];
	exp_tgt[0] = m_tgt[m_head];
	exp_tag[1] = m_tag[h1];
	exp_tgt[1] = m_tgt[h1];
	if (done_v)
		m_done[done_idx] = 1'b1;
	if (miss_v) begin
		// wrong path after the branch, captured pair is lost
		j = (int'(miss_idx) + 1) % QENTRIES;
		while (j != m_tail) begin
			m_v[j] = 1'b0;
			j = (j + 1) % QENTRIES;
		end
		m_tail = (int'(miss_idx) + 1) % QENTRIES;
	end else begin
		for (int s = 0; s < 2; s++) begin
			if ((s == 0 && cap_en0) || (s == 1 && cap_en1)) begin
				m_v[m_tail] = 1'b1;
				m_done[m_tail] = 1'b0;
				m_tag[m_tail] = cap_tag[s];
				m_tgt[m_tail] = cap_tgt[s];
				m_tail = (m_tail + 1) % QENTRIES;
			end
		end
	end
	if (r0)
		m_v[m_head] = 1'b0;
	if (r1)
		m_v[h1] = 1'b0;
	m_head = (m_head + int'(r0) + int'(r1)) % QENTRIES;
	// lone slot 1 moves to slot 0, a backward branch in slot 0 drops slot 1
	cap_en0 = (in0_v && (in1_v || pred_passes(pred_mask, pred_val))) || (!in0_v && in1_v);
	cap_en1 = in0_v && in1_v && !in0_backbr;
	cap_tag[0] = in0_v ? in0_tag : in1_tag;
	cap_tgt[0] = in0_v ? in0_tgt : in1_tgt;
	cap_tag[1] = in1_tag;
	cap_tgt[1] = in1_tgt;
endtask

`endif

// File: testbench/tb_iq_top.sv
// ==========================================================================
// instruction queue testbench
// lfsr driven fetch pairs, done marks and branch misses, with commit
// outputs and queue_full compared against a reference model each cycle
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_iq_top import iq_pkg::*; ();

	localparam int QENTRIES     = 8;
	localparam int IW           = $clog2(QENTRIES);
	localparam int STIM_CYCLES  = 2000;
	// draining takes a few cycles per entry, this is far more than needed
	localparam int DRAIN_CYCLES = 1000;
	localparam int MAX_CYCLES   = STIM_CYCLES + DRAIN_CYCLES;

	logic          clk;
	logic          rst;
	logic          in0_v;
	logic          in1_v;
	tag_t          in0_tag;
	reg_t          in0_tgt;
	logic          in0_backbr;
	tag_t          in1_tag;
	reg_t          in1_tgt;
	logic          in1_backbr;
	logic [1:0]    pred_mask;
	logic [1:0]    pred_val;
	logic          done_v;
	logic [IW-1:0] done_idx;
	logic          miss_v;
	logic [IW-1:0] miss_idx;
	logic          queue_full;
	logic          cmt0_v;
	tag_t          cmt0_tag;
	reg_t          cmt0_tgt;
	logic          cmt1_v;
	tag_t          cmt1_tag;
	reg_t          cmt1_tgt;

	logic [15:0]   lfsr_state;
	tag_t          next_tag;
	int            n_checks;
	int            n_errors;
	int            cycles = 0;

	`include "tb_iq_model.svh"

	iq_top #(.QENTRIES(QENTRIES)) uut (
		.clk, .rst, .in0_v, .in1_v, .in0_tag, .in0_tgt, .in0_backbr,
		.in1_tag, .in1_tgt, .in1_backbr, .pred_mask, .pred_val,
		.done_v, .done_idx, .miss_v, .miss_idx, .queue_full,
		.cmt0_v, .cmt0_tag, .cmt0_tgt, .cmt1_v, .cmt1_tag, .cmt1_tgt
	);

	// 4 ns period
	always #2 clk = ~clk;

	// run limit in rising edges from time zero
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: queue did not drain within %0d cycles", MAX_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	// ======================================================================
	// random bits
	// ======================================================================

	// 16-bit galois lfsr, returns the bit shifted out
	function automatic logic lfsr_next();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
			val = {val[30:0], lfsr_next()};
		return val;
	endfunction

	// ======================================================================
	// checking
	// ======================================================================

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("[ERROR] t=%0t %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	// tags and targets only mean something while the strobe is up
	task automatic compare_outputs();
		check_value("cmt0_v", 32'(cmt0_v), 32'(exp_v[0]));
		check_value("cmt1_v", 32'(cmt1_v), 32'(exp_v[1]));
		if (exp_v[0]) begin
			check_value("cmt0_tag", 32'(cmt0_tag), 32'(exp_tag[0]));
			check_value("cmt0_tgt", 32'(cmt0_tgt), 32'(exp_tgt[0]));
		end
		if (exp_v[1]) begin
			check_value("cmt1_tag", 32'(cmt1_tag), 32'(exp_tag[1]));
			check_value("cmt1_tgt", 32'(cmt1_tgt), 32'(exp_tgt[1]));
		end
		check_value("queue_full", 32'(queue_full), 32'(free_entries() < 4));
	endtask

	// ======================================================================
	// stimulus
	// ======================================================================

	task automatic pick_inputs();
		int   idx;
		logic go;
		// source holds off while fewer than four entries are free
		if (free_entries() < 4) begin
			in0_v = 1'b0;
			in1_v = 1'b0;
		end else begin
			in0_v = take_bits(1) != 0;
			in1_v = take_bits(1) != 0;
		end
		in0_tag = next_tag;
		in1_tag = next_tag + 8'd1;
		next_tag = next_tag + 8'd2;
		in0_tgt = reg_t'(take_bits(5));
		in1_tgt = reg_t'(take_bits(5));
		in0_backbr = take_bits(2) == 0;
		in1_backbr = take_bits(2) == 0;
		pred_mask = 2'(take_bits(2));
		pred_val = 2'(take_bits(2));
		// execution finishes occupied entries in any order
		idx = int'(take_bits(IW));
		go = take_bits(2) != 0;
		done_v = go && m_v[idx];
		done_idx = IW'(idx);
		// only a branch still waiting can resolve as a miss
		idx = int'(take_bits(IW));
		go = take_bits(4) == 0;
		miss_v = go && m_v[idx] && !m_done[idx];
		miss_idx = IW'(idx);
	endtask

	// no new work, oldest waiting entry gets its done mark
	task automatic drain_inputs();
		int k;
		in0_v = 1'b0;
		in1_v = 1'b0;
		miss_v = 1'b0;
		done_v = 1'b0;
		for (k = QENTRIES - 1; k >= 0; k--) begin
			if (m_v[(m_head + k) % QENTRIES] && !m_done[(m_head + k) % QENTRIES]) begin
				done_v = 1'b1;
				done_idx = IW'((m_head + k) % QENTRIES);
			end
		end
	endtask

	// called just after a falling edge
	task automatic run_cycle(input logic stim);
		compare_outputs();
		if (stim)
			pick_inputs();
		else
			drain_inputs();
		advance_model();
		@(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in0_v = 1'b0;
		in1_v = 1'b0;
		in0_tag = '0;
		in0_tgt = '0;
		in0_backbr = 1'b0;
		in1_tag = '0;
		in1_tgt = '0;
		in1_backbr = 1'b0;
		pred_mask = '0;
		pred_val = '0;
		done_v = 1'b0;
		done_idx = '0;
		miss_v = 1'b0;
		miss_idx = '0;
		lfsr_state = 16'd9;
		next_tag = '0;
		n_checks = 0;
		n_errors = 0;
		clear_model();

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int c = 0; c < STIM_CYCLES; c++)
			run_cycle(1'b1);
		while (queue_busy())
			run_cycle(1'b0);
		// last commits show up one edge after the queue empties
		repeat (2) run_cycle(1'b0);

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
